/* list.f */
source/displayPkg.sv
source/wbDisplayRegs.sv
source/digitScanner.sv
source/segmentEncoder.sv
source/hexDisplayTop.sv
test/hexDisplayProperties.sv
test/hexDisplayTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the hex display testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module hexDisplayTb \
    -f list.f \
    -o hexDisplaySim

# a failing run still leaves its log for the check below
./obj_dir/hexDisplaySim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* source/digitScanner.sv */
`timescale 1ns/100ps
`default_nettype none

module digitScanner import displayPkg::*; (
    input wire logic Clk,
    input wire logic rst,
    // register contents
    input wire displayWord_t displayWord,
    input wire logic rawMode,
    input wire logic [NumDigits-1:0] blankMask,
    input wire logic [NumDigits-1:0] dpMask,
    // active digit and its source, all combinational
    output logic [NumDigits-1:0] digitSel,
    output logic [3:0] digitValue,
    output segPattern_t rawPattern,
    output logic useRaw,
    output logic dpOn,
    output logic blank
);

    ////////////////////////////////////////////////////////////
    // refresh counter
    ////////////////////////////////////////////////////////////

    // low bits divide the clock, top bits name the digit
    localparam int CntBits = ScanDivBits + DigitIdxBits;

    logic [CntBits-1:0] refreshCnt;
    logic [DigitIdxBits-1:0] digitIdx;
    segPattern_t rawByte;

    // free running, wraps after the last digit
    always_ff @(posedge Clk) begin
        if (rst) begin
            refreshCnt <= '0;
        end else begin
            refreshCnt <= refreshCnt + 1'b1;
        end
    end

    // digit changes every 2**ScanDivBits clocks, order 0 1 2 3
    assign digitIdx = refreshCnt[CntBits-1 -: DigitIdxBits];

    // one-hot select, bit 0 is the rightmost digit
    assign digitSel = NumDigits'(1) << digitIdx;

    ////////////////////////////////////////////////////////////
    // per digit source selection
    ////////////////////////////////////////////////////////////

    // hex view nibble for the active digit
    assign digitValue = displayWord.hexView.digit[digitIdx];

    // raw view byte for the active digit
    assign rawByte = displayWord.rawView[digitIdx];

    // in raw mode the byte's own dp is merged with the dp mask
    assign rawPattern = {rawByte[7] | dpMask[digitIdx], rawByte[6:0]};

    // mode is global, masks are per digit
    assign useRaw = rawMode;
    assign dpOn = dpMask[digitIdx];
    assign blank = blankMask[digitIdx];

endmodule

`default_nettype wire

/* source/displayPkg.sv */
`default_nettype none

package displayPkg;

    ////////////////////////////////////////////////////////////
    // display geometry and refresh
    ////////////////////////////////////////////////////////////

    // four digits, digit 0 is the rightmost
    localparam int NumDigits = 4;
    // bits needed to index one digit
    localparam int DigitIdxBits = $clog2(NumDigits);
    // low counter bits per digit, 2**4 = 16 clocks per digit
    localparam int ScanDivBits = 4;

    ////////////////////////////////////////////////////////////
    // wishbone bus and register map
    ////////////////////////////////////////////////////////////

    localparam int WbAddrWidth = 2;
    localparam int WbDataWidth = 32;
    localparam int WbSelWidth = WbDataWidth / 8;

    // word addresses, the other two read back as zero
    localparam logic [WbAddrWidth-1:0] AddrDisplay = 2'd0;
    localparam logic [WbAddrWidth-1:0] AddrControl = 2'd1;

    // control word fields
    localparam int CtrlRawBit = 0;
    localparam int CtrlBlankLsb = 4;
    localparam int CtrlDpLsb = 8;

    ////////////////////////////////////////////////////////////
    // digit pattern and display word
    ////////////////////////////////////////////////////////////

    // bit 7 is dp, bits 6..0 are segments g..a, active high
    typedef logic [7:0] segPattern_t;

    // one register, read as hex nibbles or as raw segment bytes
    typedef union packed {
        struct packed {
            logic [WbDataWidth-4*NumDigits-1:0] pad;
            logic [NumDigits-1:0][3:0] digit;
        } hexView;
        segPattern_t [NumDigits-1:0] rawView;
    } displayWord_t;

endpackage

`default_nettype wire

/* source/hexDisplayTop.sv */
`timescale 1ns/100ps
`default_nettype none

module hexDisplayTop import displayPkg::*; (
    input wire logic Clk,
    input wire logic rst,
    // wishbone classic slave
    input wire logic wbCyc,
    input wire logic wbStb,
    input wire logic wbWe,
    input wire logic [WbAddrWidth-1:0] wbAddr,
    input wire logic [WbDataWidth-1:0] wbDatIn,
    input wire logic [WbSelWidth-1:0] wbSel,
    output logic [WbDataWidth-1:0] wbDatOut,
    output logic wbAck,
    // display pins, active low
    output segPattern_t segN,
    output logic [NumDigits-1:0] anodeN
);

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    // registers to scanner
    displayWord_t displayWord;
    logic rawMode;
    logic [NumDigits-1:0] blankMask;
    logic [NumDigits-1:0] dpMask;

    // scanner to encoder
    logic [NumDigits-1:0] digitSel;
    logic [3:0] digitValue;
    segPattern_t rawPattern;
    logic useRaw;
    logic dpOn;
    logic blank;

    ////////////////////////////////////////////////////////////
    // bus registers, scan, encode
    ////////////////////////////////////////////////////////////

    wbDisplayRegs regs_i (
        .Clk(Clk), .rst(rst),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAddr(wbAddr),
        .wbDatIn(wbDatIn), .wbSel(wbSel), .wbDatOut(wbDatOut), .wbAck(wbAck),
        .displayWord(displayWord), .rawMode(rawMode),
        .blankMask(blankMask), .dpMask(dpMask)
    );

    digitScanner scanner_i (
        .Clk(Clk), .rst(rst),
        .displayWord(displayWord), .rawMode(rawMode),
        .blankMask(blankMask), .dpMask(dpMask),
        .digitSel(digitSel), .digitValue(digitValue), .rawPattern(rawPattern),
        .useRaw(useRaw), .dpOn(dpOn), .blank(blank)
    );

    // one clock from select to pins
    segmentEncoder encoder_i (
        .Clk(Clk), .rst(rst),
        .digitSel(digitSel), .digitValue(digitValue), .rawPattern(rawPattern),
        .useRaw(useRaw), .dpOn(dpOn), .blank(blank),
        .segN(segN), .anodeN(anodeN)
    );

endmodule

`default_nettype wire

/* source/segmentEncoder.sv */
`timescale 1ns/100ps
`default_nettype none

module segmentEncoder import displayPkg::*; (
    input wire logic Clk,
    input wire logic rst,
    // from the scanner
    input wire logic [NumDigits-1:0] digitSel,
    input wire logic [3:0] digitValue,
    input wire segPattern_t rawPattern,
    input wire logic useRaw,
    input wire logic dpOn,
    input wire logic blank,
    // display pins, active low
    output segPattern_t segN,
    output logic [NumDigits-1:0] anodeN
);

    ////////////////////////////////////////////////////////////
    // hex to seven segment table
    ////////////////////////////////////////////////////////////

    logic [6:0] hexSeg;
    segPattern_t segNext;

    // bit order g f e d c b a, lower case b and d
    always_comb begin
        case (digitValue)
            4'h0: hexSeg = 7'h3F;
            4'h1: hexSeg = 7'h06;
            4'h2: hexSeg = 7'h5B;
            4'h3: hexSeg = 7'h4F;
            4'h4: hexSeg = 7'h66;
            4'h5: hexSeg = 7'h6D;
            4'h6: hexSeg = 7'h7D;
            4'h7: hexSeg = 7'h07;
            4'h8: hexSeg = 7'h7F;
            4'h9: hexSeg = 7'h6F;
            4'hA: hexSeg = 7'h77;
            4'hB: hexSeg = 7'h7C;
            4'hC: hexSeg = 7'h39;
            4'hD: hexSeg = 7'h5E;
            4'hE: hexSeg = 7'h79;
            default: hexSeg = 7'h71;
        endcase
    end

    // blank wins over both sources, dp included
    always_comb begin
        if (blank) begin
            segNext = '0;
        end else if (useRaw) begin
            segNext = rawPattern;
        end else begin
            segNext = {dpOn, hexSeg};
        end
    end

    ////////////////////////////////////////////////////////////
    // output registers
    ////////////////////////////////////////////////////////////

    // invert and register so the pins never glitch
    always_ff @(posedge Clk) begin
        if (rst) begin
            // all dark
            segN <= '1;
            anodeN <= '1;
        end else begin
            segN <= ~segNext;
            // anode stays on for a blanked digit
            anodeN <= ~digitSel;
        end
    end

endmodule

`default_nettype wire

/* source/wbDisplayRegs.sv */
`timescale 1ns/100ps
`default_nettype none

module wbDisplayRegs import displayPkg::*; (
    input wire logic Clk,
    input wire logic rst,
    // wishbone classic slave
    input wire logic wbCyc,
    input wire logic wbStb,
    input wire logic wbWe,
    input wire logic [WbAddrWidth-1:0] wbAddr,
    input wire logic [WbDataWidth-1:0] wbDatIn,
    input wire logic [WbSelWidth-1:0] wbSel,
    output logic [WbDataWidth-1:0] wbDatOut,
    output logic wbAck,
    // register contents toward the scanner
    output displayWord_t displayWord,
    output logic rawMode,
    output logic [NumDigits-1:0] blankMask,
    output logic [NumDigits-1:0] dpMask
);

    ////////////////////////////////////////////////////////////
    // byte lane merge
    ////////////////////////////////////////////////////////////

    // replace only the bytes whose select bit is set
    function automatic logic [WbDataWidth-1:0] mergeLanes(
        input logic [WbDataWidth-1:0] oldWord,
        input logic [WbDataWidth-1:0] newWord,
        input logic [WbSelWidth-1:0] sel
    );
        logic [WbDataWidth-1:0] merged;
        merged = oldWord;
        for (int lane = 0; lane < WbSelWidth; lane++) begin
            if (sel[lane]) begin
                merged[lane*8 +: 8] = newWord[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    logic reqStart;
    logic [WbDataWidth-1:0] controlReg;
    logic [WbDataWidth-1:0] readMux;

    // new request, held requests are not acked a second time
    assign reqStart = wbCyc & wbStb & ~wbAck;

    ////////////////////////////////////////////////////////////
    // acknowledge and register writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            wbAck <= 1'b0;
            displayWord <= '0;
            controlReg <= '0;
        end else begin
            // single cycle ack, one clock after the request
            wbAck <= reqStart;
            // write lands on the same edge the ack rises
            if (reqStart && wbWe) begin
                if (wbAddr == AddrDisplay) begin
                    displayWord <= mergeLanes(displayWord, wbDatIn, wbSel);
                end
                if (wbAddr == AddrControl) begin
                    controlReg <= mergeLanes(controlReg, wbDatIn, wbSel);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (wbAddr)
            AddrDisplay: readMux = displayWord;
            AddrControl: readMux = controlReg;
            // unmapped words read as zero
            default: readMux = '0;
        endcase
    end

    // capture with the ack so data is stable while ack is high
    always_ff @(posedge Clk) begin
        if (reqStart && !wbWe) begin
            wbDatOut <= readMux;
        end
    end

    // control word fields
    assign rawMode = controlReg[CtrlRawBit];
    assign blankMask = controlReg[CtrlBlankLsb +: NumDigits];
    assign dpMask = controlReg[CtrlDpLsb +: NumDigits];

endmodule

`default_nettype wire

/* test/hexDisplayGolden.txt */
# op 0 write, 1 read-check, 2 scan-check | addr | sel | data (expected word on read-check)
# e0 e1 e2 e3 are the expected segN of digits 0 to 3 on a scan-check, ignored otherwise
2 0 0 00000000 C0 C0 C0 C0
1 0 0 00000000 00 00 00 00
1 1 0 00000000 00 00 00 00
0 0 F 0000A3F7 00 00 00 00
1 0 0 0000A3F7 00 00 00 00
2 0 0 00000000 F8 8E B0 88
0 1 F 00000050 00 00 00 00
2 0 0 00000000 FF 8E FF 88
0 1 F 00000A00 00 00 00 00
2 0 0 00000000 F8 0E B0 08
1 1 0 00000A00 00 00 00 00
0 0 F 5B4F0677 00 00 00 00
0 1 F 00000201 00 00 00 00
2 0 0 00000000 88 79 B0 A4
0 0 2 FFFF80FF 00 00 00 00
1 0 0 5B4F8077 00 00 00 00
2 0 0 00000000 88 7F B0 A4
0 1 F 00000081 00 00 00 00
0 0 4 00CF0000 00 00 00 00
2 0 0 00000000 88 7F 30 FF
1 1 0 00000081 00 00 00 00
0 2 F DEADBEEF 00 00 00 00
1 2 0 00000000 00 00 00 00
1 3 0 00000000 00 00 00 00
0 1 F 00000000 00 00 00 00
0 0 F 0000B6D1 00 00 00 00
2 0 0 00000000 F9 A1 82 83
0 0 F 0000EC92 00 00 00 00
2 0 0 00000000 A4 90 C6 86
0 0 F 00008540 00 00 00 00
2 0 0 00000000 C0 99 92 80
1 0 0 00008540 00 00 00 00

/* test/hexDisplayProperties.sv */
`timescale 1ns/100ps
`default_nettype none

module hexDisplayProperties import displayPkg::*; (
    input wire logic Clk,
    input wire logic rst,
    input wire logic wbCyc,
    input wire logic wbStb,
    input wire logic wbAck,
    input wire logic [NumDigits-1:0] anodeN
);

    ////////////////////////////////////////////////////////////
    // digit period phase
    ////////////////////////////////////////////////////////////

    // counts in step with the low bits of the refresh counter
    logic [ScanDivBits-1:0] phaseCnt;

    always_ff @(posedge Clk) begin
        if (rst) begin
            phaseCnt <= '0;
        end else begin
            phaseCnt <= phaseCnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // bus and scan checks
    ////////////////////////////////////////////////////////////

    // one ack per request, never repeated while stb is held
    ackSingle: assert property (@(posedge Clk) disable iff (rst)
        wbCyc && wbStb && wbAck |=> !wbAck)
        else $error("wbAck stayed high for two cycles");

    // all dark only on the first clock out of reset
    anodeOneLow: assert property (@(posedge Clk) disable iff (rst)
        $onehot(~anodeN) || (anodeN == '1 && $past(rst)))
        else $error("anodeN does not have exactly one low bit");

    // the output register adds one clock to the counter boundary
    anodeBoundary: assert property (@(posedge Clk) disable iff (rst)
        !$stable(anodeN) |-> phaseCnt == ScanDivBits'(1))
        else $error("anodeN changed away from a digit period boundary");

endmodule

`default_nettype wire

/* test/hexDisplayTb.sv */
`timescale 1ns/100ps
`default_nettype none

module hexDisplayTb import displayPkg::*; ();

    ////////////////////////////////////////////////////////////
    // constants and signals
    ////////////////////////////////////////////////////////////

    localparam int ClkPeriod = 10;
    localparam int ResetCycles = 10;
    // clocks each digit stays lit
    localparam int DigitCycles = 1 << ScanDivBits;
    localparam int AckLimit = 4;

    // golden operation codes
    localparam int OpWrite = 0;
    localparam int OpRead = 1;
    localparam int OpScan = 2;

    logic Clk;
    logic rst;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [WbAddrWidth-1:0] wbAddr;
    logic [WbDataWidth-1:0] wbDatIn;
    logic [WbSelWidth-1:0] wbSel;
    logic [WbDataWidth-1:0] wbDatOut;
    logic wbAck;
    segPattern_t segN;
    logic [NumDigits-1:0] anodeN;

    // golden steps with one entry per data line
    int opQ[$];
    logic [WbAddrWidth-1:0] addrQ[$];
    logic [WbSelWidth-1:0] selQ[$];
    logic [WbDataWidth-1:0] dataQ[$];
    // expected segN where byte n belongs to digit n
    logic [NumDigits*8-1:0] expQ[$];

    int cycleCount = 0;
    // zero until the golden file is loaded
    int cycleLimit = 0;

    hexDisplayTop dut_i (
        .Clk(Clk), .rst(rst),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAddr(wbAddr),
        .wbDatIn(wbDatIn), .wbSel(wbSel), .wbDatOut(wbDatOut), .wbAck(wbAck),
        .segN(segN), .anodeN(anodeN)
    );

    // bus and scan assertions
    bind hexDisplayTop hexDisplayProperties props_i (
        .Clk(Clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb),
        .wbAck(wbAck), .anodeN(anodeN)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    ////////////////////////////////////////////////////////////
    // failure, compare and watchdog
    ////////////////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkSegments(input segPattern_t actual, input segPattern_t expected,
                                 input int digit);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch segN digit %0d: got 0x%h, expected 0x%h",
                               digit, actual, expected));
        end
    endtask

    task automatic checkReadback(input logic [WbDataWidth-1:0] actual,
                                 input logic [WbDataWidth-1:0] expected,
                                 input logic [WbAddrWidth-1:0] addr);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch wbDatOut addr 0x%h: got 0x%h, expected 0x%h",
                               addr, actual, expected));
        end
    endtask

    // ends a run that stalls anywhere
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            abortRun($sformatf("timeout, run did not finish within %0d cycles", cycleLimit));
        end
    end

    ////////////////////////////////////////////////////////////
    // wishbone master
    ////////////////////////////////////////////////////////////

    // called right after the request edge and returns at the negedge with ack high
    task automatic waitAck();
        int waited;
        waited = 0;
        do begin
            @(negedge Clk);
            waited++;
        end while (!wbAck && waited <= AckLimit);
        if (!wbAck) begin
            abortRun("wbAck did not arrive within 4 cycles of the request");
        end
        // ack is registered so it must rise exactly one clock later
        if (waited != 2) begin
            abortRun($sformatf("wbAck arrived %0d cycles after the request", waited - 1));
        end
    endtask

    task automatic wbWrite(input logic [WbAddrWidth-1:0] addr,
                           input logic [WbSelWidth-1:0] sel,
                           input logic [WbDataWidth-1:0] data);
        @(posedge Clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= 1'b1;
        wbAddr <= addr;
        wbSel <= sel;
        wbDatIn <= data;
        waitAck();
        @(posedge Clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
    endtask

    task automatic wbRead(input logic [WbAddrWidth-1:0] addr,
                          output logic [WbDataWidth-1:0] data);
        @(posedge Clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= 1'b0;
        wbAddr <= addr;
        wbSel <= '1;
        waitAck();
        // read data is valid while ack is high
        data = wbDatOut;
        @(posedge Clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // display scan
    ////////////////////////////////////////////////////////////

    // index of the single low anode or -1 when not one-hot
    function automatic int activeDigit(input logic [NumDigits-1:0] anode);
        int found;
        found = -1;
        for (int d = 0; d < NumDigits; d++) begin
            if (anode === ~(NumDigits'(1) << d)) begin
                found = d;
            end
        end
        return found;
    endfunction

    // called at a negedge and returns at the first negedge with a new anode
    task automatic waitAnodeStep();
        logic [NumDigits-1:0] startAnode;
        int waited;
        startAnode = anodeN;
        waited = 0;
        while (anodeN === startAnode) begin
            @(negedge Clk);
            waited++;
            if (waited > 2 * DigitCycles) begin
                abortRun("anodeN did not step to the next digit within two digit periods");
            end
        end
    endtask

    // every digit is checked on a fresh entry so older writes have settled
    task automatic verifyScan(input logic [NumDigits*8-1:0] expSeg);
        int digit;
        int prevDigit;
        logic fromReset;
        prevDigit = -1;
        @(negedge Clk);
        // anodes still dark means the scan is just leaving reset
        fromReset = (anodeN === '1);
        for (int n = 0; n < NumDigits; n++) begin
            waitAnodeStep();
            digit = activeDigit(anodeN);
            if (digit < 0) begin
                abortRun($sformatf("anodeN 0x%h does not select exactly one digit", anodeN));
            end
            // first digit out of reset is digit 0
            if (n == 0 && fromReset && digit != 0) begin
                abortRun($sformatf("scan out of reset started at digit %0d instead of 0",
                                   digit));
            end
            // rotation runs 0 1 2 3 and wraps
            if (prevDigit >= 0 && digit != (prevDigit + 1) % NumDigits) begin
                abortRun($sformatf("digit %0d followed digit %0d, out of order",
                                   digit, prevDigit));
            end
            checkSegments(segN, expSeg[digit*8 +: 8], digit);
            prevDigit = digit;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // golden playback
    ////////////////////////////////////////////////////////////

    task automatic loadGolden();
        int fd;
        int fields;
        string lineBuf;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] sel;
        logic [31:0] data;
        logic [31:0] e0;
        logic [31:0] e1;
        logic [31:0] e2;
        logic [31:0] e3;
        fd = $fopen("test/hexDisplayGolden.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open test/hexDisplayGolden.txt");
        end
        while ($fgets(lineBuf, fd) != 0) begin
            fields = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h",
                             op, addr, sel, data, e0, e1, e2, e3);
            // comment and blank lines give fewer fields
            if (fields == 8) begin
                opQ.push_back(int'(op));
                addrQ.push_back(addr[WbAddrWidth-1:0]);
                selQ.push_back(sel[WbSelWidth-1:0]);
                dataQ.push_back(data);
                expQ.push_back({e3[7:0], e2[7:0], e1[7:0], e0[7:0]});
            end
        end
        $fclose(fd);
        if (opQ.size() == 0) begin
            abortRun("golden file holds no steps");
        end
    endtask

    initial begin
        logic [WbDataWidth-1:0] readWord;
        rst <= 1'b1;
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
        wbAddr <= '0;
        wbDatIn <= '0;
        wbSel <= '0;
        loadGolden();
        // five digit periods per step plus the reset
        cycleLimit = opQ.size() * 5 * DigitCycles + ResetCycles;
        repeat (ResetCycles) @(posedge Clk);
        rst <= 1'b0;
        for (int step = 0; step < opQ.size(); step++) begin
            case (opQ[step])
                OpWrite: wbWrite(addrQ[step], selQ[step], dataQ[step]);
                OpRead: begin
                    wbRead(addrQ[step], readWord);
                    checkReadback(readWord, dataQ[step], addrQ[step]);
                end
                OpScan: verifyScan(expQ[step]);
                default: abortRun($sformatf("unknown operation %0d in golden step %0d",
                                            opQ[step], step));
            endcase
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
